//--- flist.f
source/pep9Pkg.sv
source/pep9Sequencer.sv
source/pep9Decoder.sv
source/pep9Alu.sv
source/pep9Registers.sv
source/pep9Top.sv
tests/pep9Clock.sv
tests/pep9Top_assertions.sv
tests/pep9TopTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f flist.f --top-module pep9TopTb -o pep9TopTb &&
./obj_dir/pep9TopTb | tee /dev/stderr | grep -F -x '** PASS **' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- source/pep9Alu.sv
`timescale 1ns/1ps
`default_nettype none

module pep9Alu (
    input  wire              Sysclk,
    input  wire              resetbar,
    input  wire              executeEn,
    input  pep9Pkg::decodedT decoded,
    input  pep9Pkg::byteT    regValue,
    input  pep9Pkg::flagsT   curFlags,
    output pep9Pkg::byteT    aluResult,
    output pep9Pkg::flagsT   aluFlags
);

    pep9Pkg::byteT  a;
    pep9Pkg::byteT  b;
    pep9Pkg::byteT  result;
    pep9Pkg::flagsT newFlags;
    pep9Pkg::flagsT mergedFlags;

    assign a = regValue;
    assign b = decoded.operand;

    always_comb
    begin
        result     = a;
        newFlags   = curFlags;
        newFlags.v = 1'b0;
        case (decoded.aluOp)
            pep9Pkg::aluPass: result = b;
            pep9Pkg::aluAdd:
            begin
                {newFlags.c, result} = {1'b0, a} + {1'b0, b};
                newFlags.v = (a[7] == b[7]) && (result[7] != a[7]);
            end
            pep9Pkg::aluSub:
            begin
                // a + ~b + 1, carry out means no borrow
                {newFlags.c, result} = {1'b0, a} + {1'b0, ~b} + 9'd1;
                newFlags.v = (a[7] != b[7]) && (result[7] != a[7]);
            end
            pep9Pkg::aluAnd: result = a & b;
            pep9Pkg::aluOr:  result = a | b;
            pep9Pkg::aluNot: result = ~a;
            pep9Pkg::aluNeg:
            begin
                result     = ~a + 8'd1;
                newFlags.v = (a == 8'h80);   // -128 has no positive
            end
            pep9Pkg::aluAsl:
            begin
                result     = {a[6:0], 1'b0};
                newFlags.c = a[7];
                newFlags.v = a[7] ^ a[6];
            end
            pep9Pkg::aluAsr:
            begin
                result     = {a[7], a[7:1]};
                newFlags.c = a[0];
            end
            pep9Pkg::aluRol:
            begin
                result     = {a[6:0], curFlags.c};
                newFlags.c = a[7];
            end
            pep9Pkg::aluRor:
            begin
                result     = {curFlags.c, a[7:1]};
                newFlags.c = a[0];
            end
            default: result = a;
        endcase
        newFlags.n = result[7];
        newFlags.z = (result == 8'd0);
    end

    // Masked bits come from the ALU, the rest stay as they were
    assign mergedFlags = (newFlags & decoded.flagMask) | (curFlags & ~decoded.flagMask);

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            aluResult <= '0;
            aluFlags  <= '0;
        end
        else if (executeEn)
        begin
            aluResult <= result;
            aluFlags  <= mergedFlags;
        end
    end

endmodule

`default_nettype wire

//--- source/pep9Decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pep9Decoder (
    input  wire              Sysclk,
    input  wire              resetbar,
    input  wire              capture,
    input  pep9Pkg::instrT   instr,
    input  wire              decodeEn,
    output pep9Pkg::decodedT decoded
);

    pep9Pkg::instrT    held;        // Instruction taken at the handshake
    pep9Pkg::decodedT  nextDecoded;
    pep9Pkg::specifierT spec;

    assign spec = held.specifier;

    always_ff @(posedge Sysclk)
    begin
        if (capture)
            held <= instr;
    end

    always_comb
    begin
        nextDecoded          = '0;
        nextDecoded.aluOp    = pep9Pkg::aluPass;
        nextDecoded.operand  = held.operand;
        nextDecoded.writeReg = 1'b1;
        if (spec[7:4] < 4'h6)
        begin
            // Unary, r in bit 0
            nextDecoded.regId = spec[0];
            case (spec & 8'hFE)
                pep9Pkg::opNot: {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluNot, 4'b1100};
                pep9Pkg::opNeg: {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluNeg, 4'b1110};
                pep9Pkg::opAsl: {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluAsl, 4'b1111};
                pep9Pkg::opAsr: {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluAsr, 4'b1101};
                pep9Pkg::opRol: {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluRol, 4'b0001};
                pep9Pkg::opRor: {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluRor, 4'b0001};
                default:        nextDecoded.illegal = 1'b1;
            endcase
        end
        else
        begin
            nextDecoded.regId = spec[3];
            case ({spec[7:4], 4'h0})
                pep9Pkg::opAdd: {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluAdd, 4'b1111};
                pep9Pkg::opSub: {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluSub, 4'b1111};
                pep9Pkg::opAnd: {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluAnd, 4'b1100};
                pep9Pkg::opOr:  {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluOr, 4'b1100};
                pep9Pkg::opCmp:
                begin
                    nextDecoded.aluOp    = pep9Pkg::aluSub;   // Flags only
                    nextDecoded.flagMask = 4'b1111;
                    nextDecoded.writeReg = 1'b0;
                end
                pep9Pkg::opLd:  {nextDecoded.aluOp, nextDecoded.flagMask} =
                    {pep9Pkg::aluPass, 4'b1100};
                default:        nextDecoded.illegal = 1'b1;
            endcase
            if (spec[2:0] != pep9Pkg::addrImmediate)
                nextDecoded.illegal = 1'b1;
        end
        if (nextDecoded.illegal)
        begin
            nextDecoded.aluOp    = pep9Pkg::aluPass;
            nextDecoded.writeReg = 1'b0;
            nextDecoded.flagMask = '0;
        end
    end

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
            decoded <= '0;
        else if (decodeEn)
            decoded <= nextDecoded;
    end

endmodule

`default_nettype wire

//--- source/pep9Pkg.sv
`default_nettype none

package pep9Pkg;

    typedef logic [7:0] byteT;
    typedef logic [7:0] specifierT;
    typedef logic       regIdT;     // 0 is A, 1 is X

    typedef struct packed {
        specifierT specifier;
        byteT      operand;
    } instrT;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } flagsT;

    typedef enum logic [3:0] {
        aluPass,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluNeg,
        aluAsl,
        aluAsr,
        aluRol,
        aluRor
    } aluOpT;

    typedef struct packed {
        aluOpT aluOp;
        regIdT regId;
        logic  writeReg;
        flagsT flagMask;   // Bits this op may change
        byteT  operand;
        logic  illegal;
    } decodedT;

    typedef struct packed {
        regIdT regId;
        byteT  value;
        logic  wroteReg;
        flagsT flags;
        logic  illegal;
    } retireT;

    typedef enum logic [1:0] {
        stIdle,
        stDecode,
        stExecute,
        stStore
    } seqStateT;

    // Unary opcodes, r bit cleared
    localparam specifierT opNot = 8'h18;
    localparam specifierT opNeg = 8'h1A;
    localparam specifierT opAsl = 8'h1C;
    localparam specifierT opAsr = 8'h1E;
    localparam specifierT opRol = 8'h20;
    localparam specifierT opRor = 8'h22;

    // Non-unary, upper nibble only
    localparam specifierT opAdd = 8'h60;
    localparam specifierT opSub = 8'h70;
    localparam specifierT opAnd = 8'h80;
    localparam specifierT opOr  = 8'h90;
    localparam specifierT opCmp = 8'hA0;
    localparam specifierT opLd  = 8'hC0;

    localparam logic [2:0] addrImmediate = 3'd0;

endpackage

`default_nettype wire

//--- source/pep9Registers.sv
`timescale 1ns/1ps
`default_nettype none

module pep9Registers (
    input  wire              Sysclk,
    input  wire              resetbar,
    input  wire              storeEn,
    input  pep9Pkg::decodedT decoded,
    input  pep9Pkg::byteT    aluResult,
    input  pep9Pkg::flagsT   aluFlags,
    output pep9Pkg::byteT    regValue,
    output pep9Pkg::flagsT   curFlags,
    output pep9Pkg::retireT  retire
);

    pep9Pkg::byteT  regA;
    pep9Pkg::byteT  regX;
    pep9Pkg::flagsT flags;

    assign regValue = decoded.regId ? regX : regA;
    assign curFlags = flags;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            regA  <= '0;
            regX  <= '0;
            flags <= '0;
        end
        else if (storeEn)
        begin
            if (decoded.writeReg)
            begin
                if (decoded.regId)
                    regX <= aluResult;
                else
                    regA <= aluResult;
            end
            if (!decoded.illegal)
                flags <= aluFlags;
        end
    end

    always_ff @(posedge Sysclk)
    begin
        if (storeEn)
        begin
            retire.regId    <= decoded.regId;
            retire.value    <= decoded.illegal ? 8'd0 : aluResult;
            retire.wroteReg <= decoded.writeReg;
            retire.flags    <= aluFlags;
            retire.illegal  <= decoded.illegal;
        end
    end

endmodule

`default_nettype wire

//--- source/pep9Sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pep9Sequencer (
    input  wire  Sysclk,
    input  wire  resetbar,
    input  wire  instrValid,
    output logic instrReady,
    output logic decodeEn,
    output logic executeEn,
    output logic storeEn,
    output logic retireValid
);

    pep9Pkg::seqStateT state;

    // Hold off the next instruction while the retire pulse is out
    assign instrReady = (state == pep9Pkg::stIdle) && !retireValid;

    assign decodeEn  = (state == pep9Pkg::stDecode);
    assign executeEn = (state == pep9Pkg::stExecute);
    assign storeEn   = (state == pep9Pkg::stStore);

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            state       <= pep9Pkg::stIdle;
            retireValid <= 1'b0;
        end
        else
        begin
            retireValid <= storeEn;
            case (state)
                pep9Pkg::stIdle:
                begin
                    if (instrValid && instrReady)
                        state <= pep9Pkg::stDecode;
                end
                pep9Pkg::stDecode:  state <= pep9Pkg::stExecute;
                pep9Pkg::stExecute: state <= pep9Pkg::stStore;
                pep9Pkg::stStore:   state <= pep9Pkg::stIdle;
                default:            state <= pep9Pkg::stIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/pep9Top.sv
`timescale 1ns/1ps
`default_nettype none

module pep9Top (
    input  wire             Sysclk,
    input  wire             resetbar,
    input  wire             instrValid,
    input  pep9Pkg::instrT  instr,
    output logic            instrReady,
    output logic            retireValid,
    output pep9Pkg::retireT retire
);

    logic             decodeEn;
    logic             executeEn;
    logic             storeEn;
    logic             capture;
    pep9Pkg::decodedT decoded;
    pep9Pkg::byteT    regValue;
    pep9Pkg::flagsT   curFlags;
    pep9Pkg::byteT    aluResult;
    pep9Pkg::flagsT   aluFlags;

    assign capture = instrValid && instrReady;

    pep9Sequencer seq0 (
        .Sysclk      (Sysclk),
        .resetbar    (resetbar),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .decodeEn    (decodeEn),
        .executeEn   (executeEn),
        .storeEn     (storeEn),
        .retireValid (retireValid)
    );

    pep9Decoder dec0 (
        .Sysclk   (Sysclk),
        .resetbar (resetbar),
        .capture  (capture),
        .instr    (instr),
        .decodeEn (decodeEn),
        .decoded  (decoded)
    );

    pep9Alu alu0 (
        .Sysclk    (Sysclk),
        .resetbar  (resetbar),
        .executeEn (executeEn),
        .decoded   (decoded),
        .regValue  (regValue),
        .curFlags  (curFlags),
        .aluResult (aluResult),
        .aluFlags  (aluFlags)
    );

    pep9Registers regs0 (
        .Sysclk    (Sysclk),
        .resetbar  (resetbar),
        .storeEn   (storeEn),
        .decoded   (decoded),
        .aluResult (aluResult),
        .aluFlags  (aluFlags),
        .regValue  (regValue),
        .curFlags  (curFlags),
        .retire    (retire)
    );

endmodule

`default_nettype wire

//--- tests/pep9Clock.sv
`timescale 1ns/1ps
`default_nettype none

module pep9Clock (
    output logic Sysclk,
    output logic resetbar
);

    initial
    begin
        Sysclk   = 1'b0;
        resetbar <= 1'b0;
        repeat (3) @(posedge Sysclk);
        resetbar <= 1'b1;
    end

    always #2 Sysclk = ~Sysclk;   // 4 ns period

endmodule

`default_nettype wire

//--- tests/pep9TopTb.sv
`timescale 1ns/1ps
`default_nettype none

module pep9TopTb;

    typedef struct packed {
        pep9Pkg::specifierT specifier;
        pep9Pkg::byteT      operand;
        pep9Pkg::regIdT     regId;
        pep9Pkg::byteT      value;
        logic               wroteReg;
        pep9Pkg::flagsT     flags;
        logic               illegal;
    } rowT;

    localparam int numRows   = 19;
    localparam int waitLimit = 20;   // Cycles before a wait gives up

    logic            Sysclk;
    logic            resetbar;
    logic            instrValid;
    pep9Pkg::instrT  instr;
    logic            instrReady;
    logic            retireValid;
    pep9Pkg::retireT retire;

    rowT rows [numRows];
    int  errorCount;
    int  timeoutCount;

    pep9Clock clk0 (
        .Sysclk   (Sysclk),
        .resetbar (resetbar)
    );

    pep9Top dut0 (
        .Sysclk      (Sysclk),
        .resetbar    (resetbar),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrReady  (instrReady),
        .retireValid (retireValid),
        .retire      (retire)
    );

    task automatic reportMismatch(input string name, input int expected, input int actual);
        $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        errorCount++;
    endtask

    // Rows run in order from reset, so each expects the state the one before left
    task automatic fillTable();
        // specifier, operand, regId, value, wroteReg, NZVC, illegal
        rows[0]  = {8'hC0, 8'h7F, 1'b0, 8'h7F, 1'b1, 4'b0000, 1'b0};   // LDWA
        rows[1]  = {8'h60, 8'h01, 1'b0, 8'h80, 1'b1, 4'b1010, 1'b0};   // ADDA overflow
        rows[2]  = {8'h70, 8'h80, 1'b0, 8'h00, 1'b1, 4'b0101, 1'b0};   // SUBA
        rows[3]  = {8'h98, 8'h90, 1'b1, 8'h90, 1'b1, 4'b1001, 1'b0};   // ORX, C kept
        rows[4]  = {8'h88, 8'h0F, 1'b1, 8'h00, 1'b1, 4'b0101, 1'b0};   // ANDX
        rows[5]  = {8'hA0, 8'h05, 1'b0, 8'hFB, 1'b0, 4'b1000, 1'b0};   // CMPWA
        rows[6]  = {8'h80, 8'hFF, 1'b0, 8'h00, 1'b1, 4'b0100, 1'b0};   // ANDA, A untouched
        rows[7]  = {8'h18, 8'h00, 1'b0, 8'hFF, 1'b1, 4'b1000, 1'b0};   // NOTA
        rows[8]  = {8'h1A, 8'h00, 1'b0, 8'h01, 1'b1, 4'b0000, 1'b0};   // NEGA
        rows[9]  = {8'hC8, 8'h80, 1'b1, 8'h80, 1'b1, 4'b1000, 1'b0};   // LDWX
        rows[10] = {8'h1B, 8'h00, 1'b1, 8'h80, 1'b1, 4'b1010, 1'b0};   // NEGX of -128
        rows[11] = {8'h1C, 8'h00, 1'b0, 8'h02, 1'b1, 4'b0000, 1'b0};   // ASLA
        rows[12] = {8'h1F, 8'h00, 1'b1, 8'hC0, 1'b1, 4'b1000, 1'b0};   // ASRX
        rows[13] = {8'h1D, 8'h00, 1'b1, 8'h80, 1'b1, 4'b1001, 1'b0};   // ASLX sets C
        rows[14] = {8'h20, 8'h00, 1'b0, 8'h05, 1'b1, 4'b1000, 1'b0};   // ROLA takes C in
        rows[15] = {8'h22, 8'h00, 1'b0, 8'h02, 1'b1, 4'b1001, 1'b0};   // RORA gives C back
        rows[16] = {8'h61, 8'h33, 1'b0, 8'h00, 1'b0, 4'b1001, 1'b1};   // ADDA direct
        rows[17] = {8'h27, 8'h00, 1'b1, 8'h00, 1'b0, 4'b1001, 1'b1};   // Unlisted unary
        rows[18] = {8'h90, 8'h00, 1'b0, 8'h02, 1'b1, 4'b0001, 1'b0};   // ORA
    endtask

    task automatic waitForReset(output bit ok);
        int waitCount;
        waitCount = 0;
        ok = 1'b0;
        while (!ok && waitCount < waitLimit)
        begin
            @(negedge Sysclk);
            waitCount++;
            ok = resetbar;
        end
    endtask

    task automatic waitForReady(output bit ok);
        int waitCount;
        waitCount = 0;
        ok = 1'b0;
        while (!ok && waitCount < waitLimit)
        begin
            @(negedge Sysclk);
            waitCount++;
            ok = instrReady;
        end
    endtask

    // Counts cycles from the handshake edge, ready must stay low meanwhile
    task automatic waitForRetire(output int latency, output bit ok);
        latency = 0;
        ok = 1'b0;
        while (!ok && latency < waitLimit)
        begin
            @(negedge Sysclk);
            latency++;
            if (instrReady !== 1'b0)
                reportMismatch("instrReady", 0, int'(instrReady));
            ok = retireValid;
        end
    endtask

    task automatic checkRetire(input rowT expected, input int latency);
        if (latency != 4)
            reportMismatch("retire latency", 4, latency);
        if (retire.regId !== expected.regId)
            reportMismatch("retire.regId", int'(expected.regId), int'(retire.regId));
        if (retire.value !== expected.value)
            reportMismatch("retire.value", int'(expected.value), int'(retire.value));
        if (retire.wroteReg !== expected.wroteReg)
            reportMismatch("retire.wroteReg", int'(expected.wroteReg), int'(retire.wroteReg));
        if (retire.flags !== expected.flags)
            reportMismatch("retire.flags", int'(expected.flags), int'(retire.flags));
        if (retire.illegal !== expected.illegal)
            reportMismatch("retire.illegal", int'(expected.illegal), int'(retire.illegal));
    endtask

    initial
    begin
        bit ok;
        int latency;
        int i;
        $timeformat(-9, 0, " ns", 0);
        errorCount   = 0;
        timeoutCount = 0;
        instrValid <= 1'b0;
        instr      <= '0;
        fillTable();

        waitForReset(ok);
        if (!ok)
        begin
            $display("Timed out waiting for reset to be released");
            timeoutCount++;
        end
        else
        begin
            if (instrReady !== 1'b1)
                reportMismatch("instrReady", 1, int'(instrReady));
            if (retireValid !== 1'b0)
                reportMismatch("retireValid", 0, int'(retireValid));
        end

        for (i = 0; i < numRows && timeoutCount == 0; i++)
        begin
            @(posedge Sysclk);
            instrValid <= 1'b1;
            instr      <= {rows[i].specifier, rows[i].operand};
            waitForReady(ok);
            if (!ok)
            begin
                $display("Timed out waiting for instrReady on row %0d", i);
                timeoutCount++;
            end
            else
            begin
                @(posedge Sysclk);   // Handshake edge
                instrValid <= 1'b0;
                waitForRetire(latency, ok);
                if (!ok)
                begin
                    $display("Timed out waiting for retireValid on row %0d", i);
                    timeoutCount++;
                end
                else
                    checkRetire(rows[i], latency);
            end
        end

        $display("Summary: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/pep9Top_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module pep9TopAssertions (
    input wire Sysclk,
    input wire resetbar,
    input wire instrValid,
    input wire instrReady,
    input wire retireValid
);

    // Retire is a single-cycle pulse
    retirePulse: assert property (@(posedge Sysclk) disable iff (!resetbar)
        retireValid |=> !retireValid)
        else $error("retireValid held high for two cycles");

    readyLowOnRetire: assert property (@(posedge Sysclk) disable iff (!resetbar)
        retireValid |-> !instrReady)
        else $error("instrReady high while retireValid is high");

    // Decode, execute, store, then the pulse
    retireAfterHandshake: assert property (@(posedge Sysclk) disable iff (!resetbar)
        (instrValid && instrReady) |-> ##4 retireValid)
        else $error("No retire 4 cycles after a handshake");

endmodule

bind pep9Top pep9TopAssertions assertions0 (
    .Sysclk      (Sysclk),
    .resetbar    (resetbar),
    .instrValid  (instrValid),
    .instrReady  (instrReady),
    .retireValid (retireValid)
);

`default_nettype wire
